// ==== Makefile ====
VERILATOR   ?= verilator
TOP         ?= tb_decode_stage
DUT         ?= decode_stage
FILELIST    ?= all.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing
PASS_TEXT   ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+bench
logic/decode_pkg.sv
logic/id_stage_reg.sv
logic/imm_gen.sv
logic/instr_decoder.sv
logic/operand_select.sv
logic/decode_stage.sv
bench/tb_decode_stage.sv

// ==== bench/decode_model.svh ====
// Decode reference model
`ifndef decode_model_svh
`define decode_model_svh

function automatic alu_mode_e funct3_mode(input logic [2:0] f3);
    case (f3)
        3'b000:  return add;
        3'b001:  return sll;
        3'b010:  return slt;
        3'b011:  return sltu;
        3'b100:  return xor_op;
        3'b101:  return srl;
        3'b110:  return or_op;
        default: return and_op;
    endcase
endfunction

// class, alu mode and word flag of a raw instruction word
function automatic op_class_e classify(input logic [31:0] w, output alu_mode_e mode,
                                       output logic word);
    logic [2:0] f3;
    logic [6:0] f7;
    op_class_e  cls;
    f3   = w[14:12];
    f7   = w[31:25];
    cls  = illegal;
    mode = add;
    word = 1'b0;
    case (w[6:0])
        7'b0110011: begin
            if (f7 == 7'h00) begin
                cls  = alu_reg;
                mode = funct3_mode(f3);
            end else if (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)) begin
                cls  = alu_reg;
                mode = (f3 == 3'b000) ? sub : sra;
            end
        end
        7'b0010011: begin
            if (f3 == 3'b101 && w[31:26] == 6'h10) begin
                cls  = alu_imm;
                mode = sra;
            end else if (w[13:12] != 2'b01 || w[31:26] == 6'h00) begin
                cls  = alu_imm;
                mode = funct3_mode(f3);
            end
        end
        7'b0111011: begin  // addw, subw
            if (f3 == 3'b000 && (f7 == 7'h00 || f7 == 7'h20)) begin
                cls  = alu_reg;
                mode = (f7 == 7'h20) ? sub : add;
                word = 1'b1;
            end
        end
        7'b0011011: begin  // addiw
            if (f3 == 3'b000) begin
                cls  = alu_imm;
                word = 1'b1;
            end
        end
        7'b0110111: cls = lui;
        7'b0010111: cls = auipc;
        7'b1101111: cls = jal;
        7'b1100111: cls = (f3 == 3'b000) ? jalr : illegal;
        7'b1100011: begin
            if (f3[2:1] != 2'b01) begin
                cls  = branch;
                mode = sub;
            end
        end
        7'b0000011: cls = (f3 != 3'b111) ? load : illegal;
        7'b0100011: cls = f3[2] ? illegal : store;
        default: ;
    endcase
    return cls;
endfunction

// bit 1 for rs1, bit 0 for rs2
function automatic logic [1:0] sources_used(input op_class_e cls);
    case (cls)
        alu_reg, branch, store: return 2'b11;
        alu_imm, jalr, load:    return 2'b10;
        default:                return 2'b00;
    endcase
endfunction

function automatic issue_t expected_issue(input logic [31:0] w, input logic [63:0] pc,
                                          input logic [63:0] s1, input logic [63:0] s2);
    issue_t      e;
    op_class_e   cls;
    alu_mode_e   mode;
    logic        word;
    logic        shift;
    logic [63:0] imm;
    cls   = classify(w, mode, word);
    shift = (w[13:12] == 2'b01);  // funct3 001 or 101
    case (cls)
        alu_imm, jalr, load: imm = {{52{w[31]}}, w[31:20]};
        store:               imm = {{52{w[31]}}, w[31:25], w[11:7]};
        branch:              imm = {{52{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        lui, auipc:          imm = {{32{w[31]}}, w[31:12], 12'h000};
        jal:                 imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        default:             imm = '0;
    endcase
    e = '0;
    case (cls)
        alu_reg: begin
            e.alu_a = s1;
            e.alu_b = shift ? {58'b0, s2[5:0]} : s2;
        end
        alu_imm: begin
            e.alu_a = s1;
            e.alu_b = shift ? {58'b0, w[25:20]} : imm;
        end
        lui:        e.alu_a = imm;
        auipc, jal: {e.alu_a, e.alu_b} = {pc, imm};
        branch:     {e.alu_a, e.alu_b} = {s1, s2};
        jalr, load, store: {e.alu_a, e.alu_b} = {s1, imm};
        default: ;
    endcase
    e.alu_mode   = mode;
    e.alu_word   = word;
    e.op_class   = cls;
    e.rd         = w[11:7];
    e.wen        = !(cls inside {branch, store, illegal});
    e.store_data = s2;
    e.pc         = pc;
    e.inst       = w;
    return e;
endfunction

`endif

// ==== bench/tb_decode_stage.sv ====
// Decode stage testbench
`timescale 1ns/10ps
`default_nettype none

module tb_decode_stage;
    import decode_pkg::*;

    localparam int n_random  = 300;
    localparam int n_bubble  = 40;
    localparam int n_hazard  = 40;
    localparam int n_dropped = 60;
    localparam int n_items   = n_random + n_bubble + n_hazard + n_dropped;

    logic        clk;
    logic        rst;
    logic        in_valid;
    fetch_t      in_fetch;
    logic        ready;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [63:0] rs1_data;
    logic [63:0] rs2_data;
    logic [31:0] gpr_busy;
    logic        out_valid;
    issue_t      issue;

    logic [63:0] regs [32];
    integer      seed;
    int          errors;
    int          tests_run;
    int          failing_tests;

    `include "decode_model.svh"

    decode_stage uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_fetch  (in_fetch),
        .ready     (ready),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .gpr_busy  (gpr_busy),
        .out_valid (out_valid),
        .issue     (issue)
    );

    assign rs1_data = regs[rs1_addr];  // register file model
    assign rs2_data = regs[rs2_addr];

    always #20 clk = ~clk;

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // random word from the kept table
    function automatic logic [31:0] legal_inst();
        logic [31:0] w;
        logic [31:0] pick;
        w    = rand32();
        pick = rand32();
        case (pick % 11)
            0: begin
                w[6:0]   = 7'b0110011;
                w[31:25] = ((w[14:12] == 3'b000 || w[14:12] == 3'b101) && pick[8]) ?
                           7'h20 : 7'h00;
            end
            1: begin
                w[6:0] = 7'b0010011;
                if (w[14:12] == 3'b001) w[31:26] = 6'h00;
                if (w[14:12] == 3'b101) w[31:26] = pick[8] ? 6'h10 : 6'h00;
            end
            2: begin
                w[6:0]   = 7'b0111011;
                w[14:12] = 3'b000;
                w[31:25] = pick[8] ? 7'h20 : 7'h00;
            end
            3: begin
                w[6:0]   = 7'b0011011;
                w[14:12] = 3'b000;
            end
            4: w[6:0] = 7'b0110111;
            5: w[6:0] = 7'b0010111;
            6: w[6:0] = 7'b1101111;
            7: begin
                w[6:0]   = 7'b1100111;
                w[14:12] = 3'b000;
            end
            8: begin
                w[6:0] = 7'b1100011;
                if (w[14:13] == 2'b01) w[14] = 1'b1;
            end
            9: begin
                w[6:0] = 7'b0000011;
                if (w[14:12] == 3'b111) w[14:12] = 3'b110;
            end
            default: begin
                w[6:0] = 7'b0100011;
                w[14]  = 1'b0;
            end
        endcase
        return w;
    endfunction

    // mul, div, csr, ecall and other non-table words
    function automatic logic [31:0] dropped_inst();
        logic [31:0] w;
        logic [31:0] pick;
        w    = rand32();
        pick = rand32();
        case (pick % 5)
            0: {w[31:25], w[6:0]} = {7'h01, 7'b0110011};
            1: {w[31:25], w[14], w[6:0]} = {7'h01, 1'b1, 7'b0110011};
            2: begin
                w[6:0] = 7'b1110011;
                if (w[14:12] == 3'b000) w[12] = 1'b1;
            end
            3: w = 32'h00000073;
            default: w[6:0] = {pick[9:8], 5'b11111};  // long encodings
        endcase
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [319:0] expected,
                                   input logic [319:0] actual);
        errors++;
        $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic report_problem(input string text);
        errors++;
        $display("FAILED at %0t ns: %s", $time, text);
    endtask

    task automatic finish_test(input string name, input int start);
        tests_run++;
        if (errors == start) begin
            $display("test %-14s ok", name);
        end else begin
            failing_tests++;
            $display("test %-14s %0d errors", name, errors - start);
        end
    endtask

    // every held item must issue on the next cycle
    task automatic run_stream(input int n, input bit dropped, input int unsigned bubble_pct);
        int          sent;
        logic        prev_valid;
        logic [31:0] prev_w;
        logic [63:0] prev_pc;
        logic [31:0] w;
        issue_t      exp;
        sent       = 0;
        prev_valid = 1'b0;
        prev_w     = '0;
        prev_pc    = '0;
        while (sent < n || prev_valid) begin
            @(posedge clk);
            #2;
            w = dropped ? dropped_inst() : legal_inst();
            in_fetch.pc   = {rand32(), rand32()};
            in_fetch.inst = w;
            in_valid      = (sent < n) && ((rand32() % 100) >= bubble_pct);
            gpr_busy      = dropped ? '1 : '0;  // illegal items use no source
            if (in_valid) begin
                sent++;
            end
            @(negedge clk);
            if (out_valid !== prev_valid) report_mismatch("out_valid", 320'(prev_valid),
                                                          320'(out_valid));
            if (ready !== 1'b1) report_mismatch("ready", 320'(1'b1), 320'(ready));
            if (prev_valid) begin
                if (rs1_addr !== prev_w[19:15])
                    report_mismatch("rs1_addr", 320'(prev_w[19:15]), 320'(rs1_addr));
                if (rs2_addr !== prev_w[24:20])
                    report_mismatch("rs2_addr", 320'(prev_w[24:20]), 320'(rs2_addr));
                exp = expected_issue(prev_w, prev_pc, regs[prev_w[19:15]], regs[prev_w[24:20]]);
                if (issue !== exp) report_mismatch("issue", 320'(exp), 320'(issue));
                if (dropped && (issue.op_class !== illegal || issue.wen !== 1'b0 ||
                                issue.alu_a !== '0 || issue.alu_b !== '0))
                    report_problem("dropped encoding did not decode as an illegal no-op");
            end
            prev_valid = in_valid;
            prev_w     = w;
            prev_pc    = in_fetch.pc;
        end
    endtask

    task automatic run_hazard(input int n);
        int          k;
        int          hold;
        logic [31:0] w;
        logic [31:0] r;
        logic [63:0] pc;
        logic [1:0]  use_mask;
        logic [4:0]  busy_reg;
        logic [4:0]  idle_reg;
        alu_mode_e   mode;
        logic        word;
        issue_t      exp;
        for (k = 0; k < n; k++) begin
            use_mask = 2'b00;
            while (use_mask == 2'b00) begin
                w        = legal_inst();
                use_mask = sources_used(classify(w, mode, word));
            end
            r        = rand32();
            hold     = 1 + int'(r[18:16]);
            busy_reg = (use_mask[0] && r[0]) ? w[24:20] : w[19:15];
            idle_reg = use_mask[0] ? r[12:8] : w[24:20];  // unused rs2 field when possible
            while ((use_mask[1] && idle_reg == w[19:15]) || (use_mask[0] && idle_reg == w[24:20]))
                idle_reg = idle_reg + 5'd1;
            @(posedge clk);
            #2;
            pc            = {rand32(), rand32()};
            in_valid      = 1'b1;
            in_fetch.pc   = pc;
            in_fetch.inst = w;
            @(posedge clk);
            #2;
            in_valid = 1'b0;
            gpr_busy = (32'd1 << busy_reg) | (32'd1 << idle_reg);
            repeat (hold) begin
                @(negedge clk);
                if (out_valid !== 1'b0 || ready !== 1'b0)
                    report_problem("item issued or input accepted while a source was busy");
                @(posedge clk);
                #2;
            end
            gpr_busy = 32'd1 << idle_reg;
            @(negedge clk);
            exp = expected_issue(w, pc, regs[w[19:15]], regs[w[24:20]]);
            if (out_valid !== 1'b1) report_mismatch("out_valid", 320'(1'b1), 320'(out_valid));
            if (issue !== exp) report_mismatch("issue", 320'(exp), 320'(issue));
            @(posedge clk);
            #2;
            gpr_busy = '0;
            @(negedge clk);
            if (out_valid !== 1'b0) report_problem("stalled item issued more than once");
        end
    endtask

    initial begin
        repeat (n_items * 20) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("tests failed");
        $finish;
    end

    initial begin
        int i;
        int start;
        seed          = 32'hd5f4c387;
        errors        = 0;
        tests_run     = 0;
        failing_tests = 0;
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_fetch      = '0;
        gpr_busy      = '0;
        for (i = 0; i < 32; i++) begin
            regs[i] = {rand32(), rand32()};
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        start = errors;
        @(negedge clk);
        if (out_valid !== 1'b0) report_mismatch("out_valid", 320'(1'b0), 320'(out_valid));
        if (ready !== 1'b1) report_mismatch("ready", 320'(1'b1), 320'(ready));
        finish_test("reset", start);

        start = errors;
        run_stream(n_random, 1'b0, 25);
        finish_test("random legal", start);

        start = errors;
        run_stream(n_bubble, 1'b0, 50);
        finish_test("bubbles", start);

        start = errors;
        run_hazard(n_hazard);
        finish_test("hazard stall", start);

        start = errors;
        run_stream(n_dropped, 1'b1, 25);
        finish_test("dropped", start);

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, failing_tests, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/decode_pkg.sv ====
// RV64 decode stage definitions
`default_nettype none

package decode_pkg;

    localparam int xlen       = 64;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;

    // major opcodes of the kept table
    localparam logic [6:0] opc_op        = 7'b0110011;
    localparam logic [6:0] opc_op_imm    = 7'b0010011;
    localparam logic [6:0] opc_op_32     = 7'b0111011;
    localparam logic [6:0] opc_op_imm_32 = 7'b0011011;
    localparam logic [6:0] opc_lui       = 7'b0110111;
    localparam logic [6:0] opc_auipc     = 7'b0010111;
    localparam logic [6:0] opc_jal       = 7'b1101111;
    localparam logic [6:0] opc_jalr      = 7'b1100111;
    localparam logic [6:0] opc_branch    = 7'b1100011;
    localparam logic [6:0] opc_load      = 7'b0000011;
    localparam logic [6:0] opc_store     = 7'b0100011;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;  // sub, sra
    localparam logic [5:0] funct6_base = 6'b000000;   // rv64 shift-immediate forms
    localparam logic [5:0] funct6_alt  = 6'b010000;

    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm12;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;  // B format shares these positions

    typedef struct packed {
        logic [19:0]           imm20;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;  // J format shares these positions

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } inst_t;

    typedef enum logic [3:0] {
        alu_reg, alu_imm, lui, auipc, jal, jalr, branch, load, store, illegal
    } op_class_e;

    typedef enum logic [3:0] {
        add, sub, slt, sltu, and_op, or_op, xor_op, sll, srl, sra
    } alu_mode_e;

    typedef enum logic [1:0] {
        opa_src1, opa_pc, opa_imm, opa_zero
    } opa_sel_e;

    typedef enum logic [2:0] {
        opb_src2, opb_src2_low6, opb_shamt, opb_imm, opb_zero
    } opb_sel_e;

    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_t           inst;
    } fetch_t;

    typedef struct packed {
        op_class_e             op_class;
        alu_mode_e             alu_mode;
        logic                  alu_word;
        opa_sel_e              a_sel;
        opb_sel_e              b_sel;
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic                  uses_rs1;
        logic                  uses_rs2;
        logic                  wen;
    } ctrl_t;

    typedef struct packed {
        logic [xlen-1:0]       alu_a;
        logic [xlen-1:0]       alu_b;
        alu_mode_e             alu_mode;
        logic                  alu_word;
        op_class_e             op_class;
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
        logic [xlen-1:0]       store_data;
        logic [xlen-1:0]       pc;
        inst_t                 inst;
    } issue_t;

endpackage

`default_nettype wire

// ==== logic/decode_stage.sv ====
// RV64 decode stage top
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   in_valid,
    input  decode_pkg::fetch_t                     in_fetch,
    output logic                                   ready,
    output logic [decode_pkg::reg_addr_w-1:0]      rs1_addr,
    output logic [decode_pkg::reg_addr_w-1:0]      rs2_addr,
    input  logic [decode_pkg::xlen-1:0]            rs1_data,
    input  logic [decode_pkg::xlen-1:0]            rs2_data,
    input  logic [decode_pkg::num_regs-1:0]        gpr_busy,
    output logic                                   out_valid,
    output decode_pkg::issue_t                     issue
);
    import decode_pkg::*;

    logic   held_valid;
    fetch_t held_fetch;
    ctrl_t  ctrl;
    logic   stall;

    id_stage_reg u_stage_reg (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_fetch   (in_fetch),
        .stall      (stall),
        .held_valid (held_valid),
        .held_fetch (held_fetch)
    );

    instr_decoder u_decoder (
        .inst (held_fetch.inst),
        .ctrl (ctrl)
    );

    operand_select u_operand_select (
        .held_valid (held_valid),
        .held_fetch (held_fetch),
        .ctrl       (ctrl),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .gpr_busy   (gpr_busy),
        .stall      (stall),
        .out_valid  (out_valid),
        .issue      (issue)
    );

    assign ready    = !stall;
    assign rs1_addr = ctrl.rs1;  // register file read ports
    assign rs2_addr = ctrl.rs2;

endmodule

`default_nettype wire

// ==== logic/id_stage_reg.sv ====
// Decode stage register
`timescale 1ns/10ps
`default_nettype none

module id_stage_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  decode_pkg::fetch_t in_fetch,
    input  logic               stall,
    output logic               held_valid,
    output decode_pkg::fetch_t held_fetch
);

    always_ff @(posedge clk) begin
        if (rst) begin
            held_valid <= 1'b0;
        end else if (!stall) begin
            held_valid <= in_valid;  // low in_valid loads a bubble
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            held_fetch <= in_fetch;
        end
    end

    // a stalled item must survive the edge untouched
    hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        stall |=> ($stable(held_valid) && $stable(held_fetch))
    ) else $error("stage register changed during stall");

endmodule

`default_nettype wire

// ==== logic/imm_gen.sv ====
// Immediate generator
`timescale 1ns/10ps
`default_nettype none

module imm_gen (
    input  decode_pkg::inst_t             inst,
    input  decode_pkg::op_class_e         op_class,
    output logic [decode_pkg::xlen-1:0]   imm
);
    import decode_pkg::*;

    logic            sign;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign sign  = inst.u.imm20[19];  // instruction bit 31
    assign imm_i = {{(xlen-12){sign}}, inst.i.imm12};
    assign imm_s = {{(xlen-12){sign}}, inst.s.imm_hi, inst.s.imm_lo};
    assign imm_b = {{(xlen-12){sign}}, inst.s.imm_lo[0], inst.s.imm_hi[5:0],
                    inst.s.imm_lo[4:1], 1'b0};
    assign imm_u = {{(xlen-32){sign}}, inst.u.imm20, 12'b0};
    assign imm_j = {{(xlen-20){sign}}, inst.u.imm20[7:0], inst.u.imm20[8],
                    inst.u.imm20[18:9], 1'b0};

    always_comb begin
        case (op_class)
            alu_imm, jalr, load: imm = imm_i;
            store:               imm = imm_s;
            branch:              imm = imm_b;
            lui, auipc:          imm = imm_u;
            jal:                 imm = imm_j;
            default:             imm = '0;  // reg ops and illegal
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/instr_decoder.sv ====
// Instruction decoder
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
    input  decode_pkg::inst_t inst,
    output decode_pkg::ctrl_t ctrl
);
    import decode_pkg::*;

    op_class_e       op_class;
    alu_mode_e       alu_mode;
    logic            alu_word;
    logic            shift_op;
    opa_sel_e        a_sel;
    opb_sel_e        b_sel;
    logic            uses_rs1;
    logic            uses_rs2;
    logic            wen;
    logic [xlen-1:0] imm;

    imm_gen u_imm_gen (
        .inst     (inst),
        .op_class (op_class),
        .imm      (imm)
    );

    // class and alu mode from opcode, funct3, funct7
    always_comb begin
        op_class = illegal;
        alu_mode = add;
        alu_word = 1'b0;
        shift_op = (inst.r.funct3 == 3'b001) || (inst.r.funct3 == 3'b101);
        case (inst.r.opcode)
            opc_op: begin
                if (inst.r.funct7 == funct7_base) begin
                    op_class = alu_reg;
                    case (inst.r.funct3)
                        3'b000:  alu_mode = add;
                        3'b001:  alu_mode = sll;
                        3'b010:  alu_mode = slt;
                        3'b011:  alu_mode = sltu;
                        3'b100:  alu_mode = xor_op;
                        3'b101:  alu_mode = srl;
                        3'b110:  alu_mode = or_op;
                        default: alu_mode = and_op;
                    endcase
                end else if (inst.r.funct7 == funct7_alt && inst.r.funct3 == 3'b000) begin
                    op_class = alu_reg;
                    alu_mode = sub;
                end else if (inst.r.funct7 == funct7_alt && inst.r.funct3 == 3'b101) begin
                    op_class = alu_reg;
                    alu_mode = sra;
                end
            end
            opc_op_imm: begin
                case (inst.i.funct3)
                    3'b000: {op_class, alu_mode} = {alu_imm, add};
                    3'b010: {op_class, alu_mode} = {alu_imm, slt};
                    3'b011: {op_class, alu_mode} = {alu_imm, sltu};
                    3'b100: {op_class, alu_mode} = {alu_imm, xor_op};
                    3'b110: {op_class, alu_mode} = {alu_imm, or_op};
                    3'b111: {op_class, alu_mode} = {alu_imm, and_op};
                    3'b001: begin
                        if (inst.i.imm12[11:6] == funct6_base) begin
                            {op_class, alu_mode} = {alu_imm, sll};
                        end
                    end
                    default: begin  // 101, srli or srai
                        if (inst.i.imm12[11:6] == funct6_base) begin
                            {op_class, alu_mode} = {alu_imm, srl};
                        end else if (inst.i.imm12[11:6] == funct6_alt) begin
                            {op_class, alu_mode} = {alu_imm, sra};
                        end
                    end
                endcase
            end
            opc_op_32: begin
                if (inst.r.funct3 == 3'b000 && inst.r.funct7 == funct7_base) begin
                    {op_class, alu_mode, alu_word} = {alu_reg, add, 1'b1};
                end else if (inst.r.funct3 == 3'b000 && inst.r.funct7 == funct7_alt) begin
                    {op_class, alu_mode, alu_word} = {alu_reg, sub, 1'b1};
                end
            end
            opc_op_imm_32: begin
                if (inst.i.funct3 == 3'b000) begin
                    {op_class, alu_word} = {alu_imm, 1'b1};  // addiw
                end
            end
            opc_lui:   op_class = lui;
            opc_auipc: op_class = auipc;
            opc_jal:   op_class = jal;
            opc_jalr: begin
                if (inst.i.funct3 == 3'b000) op_class = jalr;
            end
            opc_branch: begin
                if (inst.s.funct3 != 3'b010 && inst.s.funct3 != 3'b011) begin
                    {op_class, alu_mode} = {branch, sub};
                end
            end
            opc_load: begin
                if (inst.i.funct3 != 3'b111) op_class = load;  // lb..ld, lbu..lwu
            end
            opc_store: begin
                if (!inst.s.funct3[2]) op_class = store;  // sb sh sw sd
            end
            default: ;
        endcase
    end

    // operand routing per class
    always_comb begin
        a_sel    = opa_zero;
        b_sel    = opb_zero;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        wen      = 1'b0;
        case (op_class)
            alu_reg: begin
                a_sel = opa_src1;
                b_sel = shift_op ? opb_src2_low6 : opb_src2;
                {uses_rs1, uses_rs2, wen} = 3'b111;
            end
            alu_imm: begin
                a_sel = opa_src1;
                b_sel = shift_op ? opb_shamt : opb_imm;
                {uses_rs1, wen} = 2'b11;
            end
            lui:        {a_sel, wen} = {opa_imm, 1'b1};
            auipc, jal: {a_sel, b_sel, wen} = {opa_pc, opb_imm, 1'b1};
            jalr, load: {a_sel, b_sel, uses_rs1, wen} = {opa_src1, opb_imm, 2'b11};
            branch: begin
                {a_sel, b_sel} = {opa_src1, opb_src2};
                {uses_rs1, uses_rs2} = 2'b11;
            end
            store: begin
                {a_sel, b_sel} = {opa_src1, opb_imm};
                {uses_rs1, uses_rs2} = 2'b11;  // rs2 carries store data
            end
            default: ;
        endcase
    end

    always_comb begin
        assert final (!(wen && (op_class inside {branch, store, illegal})))
            else $error("write enable raised for a non-writing class");
    end

    assign ctrl = '{
        op_class: op_class,
        alu_mode: alu_mode,
        alu_word: alu_word,
        a_sel:    a_sel,
        b_sel:    b_sel,
        imm:      imm,
        rd:       inst.r.rd,
        rs1:      inst.r.rs1,
        rs2:      inst.r.rs2,
        uses_rs1: uses_rs1,
        uses_rs2: uses_rs2,
        wen:      wen
    };

endmodule

`default_nettype wire

// ==== logic/operand_select.sv ====
// Operand select and issue
`timescale 1ns/10ps
`default_nettype none

module operand_select (
    input  logic                                held_valid,
    input  decode_pkg::fetch_t                  held_fetch,
    input  decode_pkg::ctrl_t                   ctrl,
    input  logic [decode_pkg::xlen-1:0]         rs1_data,
    input  logic [decode_pkg::xlen-1:0]         rs2_data,
    input  logic [decode_pkg::num_regs-1:0]     gpr_busy,
    output logic                                stall,
    output logic                                out_valid,
    output decode_pkg::issue_t                  issue
);
    import decode_pkg::*;

    logic            conflict_rs1;
    logic            conflict_rs2;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;

    // scoreboard check, x0 included
    assign conflict_rs1 = ctrl.uses_rs1 && gpr_busy[ctrl.rs1];
    assign conflict_rs2 = ctrl.uses_rs2 && gpr_busy[ctrl.rs2];
    assign stall        = held_valid && (conflict_rs1 || conflict_rs2);
    assign out_valid    = held_valid && !(conflict_rs1 || conflict_rs2);

    always_comb begin
        case (ctrl.a_sel)
            opa_src1: opa = rs1_data;
            opa_pc:   opa = held_fetch.pc;
            opa_imm:  opa = ctrl.imm;
            default:  opa = '0;
        endcase
    end

    always_comb begin
        case (ctrl.b_sel)
            opb_src2:      opb = rs2_data;
            opb_src2_low6: opb = {{(xlen-6){1'b0}}, rs2_data[5:0]};
            opb_shamt:     opb = {{(xlen-6){1'b0}}, held_fetch.inst.i.imm12[5:0]};
            opb_imm:       opb = ctrl.imm;
            default:       opb = '0;
        endcase
    end

    always_comb begin
        assert final (!(out_valid && stall))
            else $error("issue strobe raised during a stall");
    end

    assign issue = '{
        alu_a:      opa,
        alu_b:      opb,
        alu_mode:   ctrl.alu_mode,
        alu_word:   ctrl.alu_word,
        op_class:   ctrl.op_class,
        rd:         ctrl.rd,
        wen:        ctrl.wen,
        store_data: rs2_data,
        pc:         held_fetch.pc,
        inst:       held_fetch.inst
    };

endmodule

`default_nettype wire
